// ==== uart_cfg.svh ====
//////////////////////////////////////////////////
// build-time sizes for the UART
// fifo depth is shared by the tx and rx fifos
// apb widths set the slave port of the top level
//////////////////////////////////////////////////
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// entries per fifo
`define UART_FIFO_DEPTH 16

// apb slave port
`define UART_APB_AW 12
`define UART_APB_DW 32

`endif

// ==== uart_pkg.sv ====
//////////////////////////////////////////////////
// register map and shared types of the UART
// offsets are byte addresses on PADDR[2:0]
// MCR, MSR and SCR are not implemented
//////////////////////////////////////////////////
package uart_pkg;

  // register offsets, DLL/DLM share with DLAB set
  localparam logic [2:0] REG_RBR_THR_DLL = 3'd0;
  localparam logic [2:0] REG_IER_DLM     = 3'd1;
  localparam logic [2:0] REG_IIR_FCR     = 3'd2;
  localparam logic [2:0] REG_LCR         = 3'd3;
  localparam logic [2:0] REG_LSR         = 3'd5;

  // interrupt identification, highest priority first
  typedef enum logic [3:0] {
    IIR_NONE = 4'b0001,
    IIR_LINE = 4'b0110,
    IIR_RDA  = 4'b0100,
    IIR_THRE = 4'b0010
  } iir_code_t;

  // line control register layout
  typedef struct packed {
    logic       dlab;      // divisor latch access
    logic       brk;       // stored only
    logic       stick;     // stored only
    logic       even_par;
    logic       par_en;
    logic       stop2;
    logic [1:0] wlen;      // data bits = 5 + wlen
  } lcr_t;

  // rx fifo entry
  typedef struct packed {
    logic       par_err;
    logic [7:0] data;
  } rx_entry_t;

endpackage

// ==== uart_line_if.sv ====
//////////////////////////////////////////////////
// line settings from the register file
// regs drives, tx and rx only read
//////////////////////////////////////////////////
`timescale 1ns/1ps

interface uart_line_if;
  logic [15:0] div;       // bit period is div+1 cycles
  logic [1:0]  wlen;      // data bits = 5 + wlen
  logic        par_en;
  logic        even_par;
  logic        stop2;     // two stop bits

  modport regs (output div, wlen, par_en, even_par, stop2);
  modport tx   (input  div, wlen, par_en, even_par, stop2);
  modport rx   (input  div, wlen, par_en, even_par, stop2);
endinterface

// ==== uart_baud_timer.sv ====
//////////////////////////////////////////////////
// bit period timer, div_i+1 cycles per bit
// count reloads while run_i is low so each
// frame starts phase aligned
// div_i of 3 or more keeps half tick apart
//////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_baud_timer (
  input  logic        CLK,
  input  logic        RSTN,
  input  logic        run_i,
  input  logic [15:0] div_i,
  output logic        bit_tick_o,   // last cycle of a bit
  output logic        half_tick_o   // middle of a bit
);

  logic [15:0] cnt_q;
  logic        wrap;

  assign wrap = (cnt_q == div_i);

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      cnt_q <= '0;
    end else if (!run_i || wrap) begin
      cnt_q <= '0;              // reload or restart
    end else begin
      cnt_q <= cnt_q + 16'd1;
    end
  end

  assign bit_tick_o  = run_i && wrap;
  assign half_tick_o = run_i && (cnt_q == {1'b0, div_i[15:1]});

endmodule

// ==== uart_fifo.sv ====
//////////////////////////////////////////////////
// synchronous fifo, payload type set per instance
// push when full and pop when empty are dropped
// clr_i empties in one cycle and wins over push
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = `UART_FIFO_DEPTH
) (
  input  logic                   CLK,
  input  logic                   RSTN,
  input  logic                   clr_i,
  input  logic                   push_i,
  input  payload_t               data_i,
  input  logic                   pop_i,
  output payload_t               data_o,    // head, stale when empty
  output logic                   valid_o,
  output logic [$clog2(DEPTH):0] count_o
);

  localparam int AW = $clog2(DEPTH);

  payload_t        mem [DEPTH];
  logic [AW-1:0]   wr_ptr_q;
  logic [AW-1:0]   rd_ptr_q;
  logic            push_ok;
  logic            pop_ok;

  assign push_ok = push_i && (count_o != DEPTH);
  assign pop_ok  = pop_i && valid_o;

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_o  <= '0;
    end else if (clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_o  <= '0;
    end else begin
      if (push_ok) wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop_ok)  rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      count_o <= count_o + push_ok - pop_ok;
    end
  end

  // storage
  always_ff @(posedge CLK) begin
    if (push_ok) mem[wr_ptr_q] <= data_i;
  end

  assign data_o  = mem[rd_ptr_q];
  assign valid_o = (count_o != '0);

endmodule

// ==== uart_tx.sv ====
//////////////////////////////////////////////////
// serial transmitter, one frame per fifo entry
// line settings are latched when a byte is taken
// tx_o idles high
//////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_tx (
  input  logic         CLK,
  input  logic         RSTN,
  uart_line_if.tx      line,
  input  logic [7:0]   data_i,
  input  logic         valid_i,
  output logic         take_o,    // pops the tx fifo
  output logic         idle_o,
  output logic         tx_o
);

  typedef enum logic [2:0] {
    TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP1, TX_STOP2
  } tx_state_t;

  tx_state_t   state_q;
  logic [7:0]  sh_q;        // shift register, lsb goes out first
  logic [2:0]  bit_q;       // data bit index
  logic        par_q;       // running parity
  logic [15:0] div_q;
  logic [1:0]  wlen_q;
  logic        par_en_q;
  logic        stop2_q;
  logic        bit_tick;

  uart_baud_timer u_timer (
    .CLK         (CLK),
    .RSTN        (RSTN),
    .run_i       (state_q != TX_IDLE),
    .div_i       (div_q),
    .bit_tick_o  (bit_tick),
    .half_tick_o ()            // not needed on the tx side
  );

  assign take_o = (state_q == TX_IDLE) && valid_i;
  assign idle_o = (state_q == TX_IDLE);

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      state_q  <= TX_IDLE;
      sh_q     <= '0;
      bit_q    <= '0;
      par_q    <= 1'b0;
      div_q    <= '0;
      wlen_q   <= '0;
      par_en_q <= 1'b0;
      stop2_q  <= 1'b0;
    end else begin
      case (state_q)
        TX_IDLE: if (take_o) begin
          state_q  <= TX_START;
          sh_q     <= data_i;
          bit_q    <= '0;
          par_q    <= ~line.even_par;   // odd parity starts at one
          div_q    <= line.div;
          wlen_q   <= line.wlen;
          par_en_q <= line.par_en;
          stop2_q  <= line.stop2;
        end
        TX_START: if (bit_tick) state_q <= TX_DATA;
        TX_DATA: if (bit_tick) begin
          par_q <= par_q ^ sh_q[0];
          sh_q  <= sh_q >> 1;
          bit_q <= bit_q + 3'd1;
          if (bit_q == {1'b0, wlen_q} + 3'd4) begin   // last data bit
            state_q <= par_en_q ? TX_PARITY : TX_STOP1;
          end
        end
        TX_PARITY: if (bit_tick) state_q <= TX_STOP1;
        TX_STOP1: if (bit_tick) state_q <= stop2_q ? TX_STOP2 : TX_IDLE;
        TX_STOP2: if (bit_tick) state_q <= TX_IDLE;
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  always_comb begin
    case (state_q)
      TX_START:  tx_o = 1'b0;
      TX_DATA:   tx_o = sh_q[0];
      TX_PARITY: tx_o = par_q;
      default:   tx_o = 1'b1;       // idle and stop bits
    endcase
  end

endmodule

// ==== uart_rx.sv ====
//////////////////////////////////////////////////
// serial receiver, one sample in the middle of
// each bit, no oversampling
// stop bit is sampled but not checked
// data is zero extended to 8 bits
//////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_rx (
  input  logic                 CLK,
  input  logic                 RSTN,
  uart_line_if.rx              line,
  input  logic                 rx_i,
  output logic                 push_o,    // one cycle per frame
  output uart_pkg::rx_entry_t  entry_o
);

  typedef enum logic [2:0] {
    RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP
  } rx_state_t;

  rx_state_t  state_q;
  logic       rx_s1_q;
  logic       rx_s2_q;      // synchronized line
  logic       rx_prev_q;    // for edge detect
  logic [7:0] sh_q;         // bits enter at the top
  logic [2:0] bit_q;
  logic       par_q;        // running parity
  logic       perr_q;
  logic       half_tick;

  uart_baud_timer u_timer (
    .CLK         (CLK),
    .RSTN        (RSTN),
    .run_i       (state_q != RX_IDLE),
    .div_i       (line.div),
    .bit_tick_o  (),            // sampling uses the half point only
    .half_tick_o (half_tick)
  );

  // two flop synchronizer
  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      rx_s1_q   <= 1'b1;
      rx_s2_q   <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_s1_q   <= rx_i;
      rx_s2_q   <= rx_s1_q;
      rx_prev_q <= rx_s2_q;
    end
  end

  //////////////////////////////////////////////////
  // frame state machine
  //////////////////////////////////////////////////
  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      state_q <= RX_IDLE;
      sh_q    <= '0;
      bit_q   <= '0;
      par_q   <= 1'b0;
      perr_q  <= 1'b0;
      push_o  <= 1'b0;
      entry_o <= '0;
    end else begin
      push_o <= 1'b0;
      case (state_q)
        RX_IDLE: if (rx_prev_q && !rx_s2_q) state_q <= RX_START;   // falling edge
        RX_START: if (half_tick) begin
          state_q <= rx_s2_q ? RX_IDLE : RX_DATA;   // high again is a glitch
          bit_q   <= '0;
          par_q   <= ~line.even_par;
          perr_q  <= 1'b0;
        end
        RX_DATA: if (half_tick) begin
          sh_q  <= {rx_s2_q, sh_q[7:1]};
          par_q <= par_q ^ rx_s2_q;
          bit_q <= bit_q + 3'd1;
          if (bit_q == {1'b0, line.wlen} + 3'd4) begin
            state_q <= line.par_en ? RX_PARITY : RX_STOP;
          end
        end
        RX_PARITY: if (half_tick) begin
          perr_q  <= par_q ^ rx_s2_q;   // set on mismatch
          state_q <= RX_STOP;
        end
        RX_STOP: if (half_tick) begin
          push_o          <= 1'b1;
          entry_o.par_err <= perr_q;
          entry_o.data    <= sh_q >> (2'd3 - line.wlen);   // align short words
          state_q         <= RX_IDLE;
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

endmodule

// ==== uart_regs.sv ====
//////////////////////////////////////////////////
// apb register file of the UART
// no wait states, reads of RBR pop the rx fifo
// interrupt sources are levels, never latched
// unmapped offsets read as zero
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_regs (
  input  logic                                  CLK,
  input  logic                                  RSTN,
  input  logic [`UART_APB_AW-1:0]               paddr_i,
  input  logic [`UART_APB_DW-1:0]               pwdata_i,
  input  logic                                  pwrite_i,
  input  logic                                  psel_i,
  input  logic                                  penable_i,
  output logic [`UART_APB_DW-1:0]               prdata_o,
  uart_line_if.regs                             line,
  output logic                                  tx_push_o,
  output logic [7:0]                            tx_data_o,
  output logic                                  tx_clr_o,
  input  logic [$clog2(`UART_FIFO_DEPTH):0]     tx_count_i,
  input  logic                                  tx_idle_i,
  output logic                                  rx_pop_o,
  output logic                                  rx_clr_o,
  input  uart_pkg::rx_entry_t                   rx_head_i,
  input  logic                                  rx_valid_i,
  input  logic [$clog2(`UART_FIFO_DEPTH):0]     rx_count_i,
  output logic                                  event_o
);
  import uart_pkg::*;

  localparam int CW = $clog2(`UART_FIFO_DEPTH) + 1;

  lcr_t          lcr_q;
  logic [2:0]    ier_q;       // thre, rda... bit 2 is line status
  logic [7:0]    dll_q;
  logic [7:0]    dlm_q;
  logic [1:0]    trig_q;      // rx trigger select
  logic          tx_clr_q;
  logic          rx_clr_q;
  logic          wr_en;
  logic          rd_en;
  logic [2:0]    addr;
  logic [7:0]    lsr;
  logic [CW-1:0] trig_lvl;
  iir_code_t     iir;

  assign addr  = paddr_i[2:0];
  assign wr_en = psel_i && penable_i && pwrite_i;
  assign rd_en = psel_i && penable_i && !pwrite_i;

  //////////////////////////////////////////////////
  // writes
  //////////////////////////////////////////////////
  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      lcr_q    <= '0;
      ier_q    <= '0;
      dll_q    <= '0;
      dlm_q    <= '0;
      trig_q   <= '0;
      tx_clr_q <= 1'b0;
      rx_clr_q <= 1'b0;
    end else begin
      tx_clr_q <= 1'b0;   // one cycle strobes
      rx_clr_q <= 1'b0;
      if (wr_en) begin
        case (addr)
          REG_RBR_THR_DLL: if (lcr_q.dlab) dll_q <= pwdata_i[7:0];
          REG_IER_DLM: begin
            if (lcr_q.dlab) dlm_q <= pwdata_i[7:0];
            else            ier_q <= pwdata_i[2:0];
          end
          REG_IIR_FCR: begin   // fcr is write only
            rx_clr_q <= pwdata_i[1];
            tx_clr_q <= pwdata_i[2];
            trig_q   <= pwdata_i[7:6];
          end
          REG_LCR: lcr_q <= pwdata_i[7:0];
          default: ;
        endcase
      end
    end
  end

  assign tx_push_o = wr_en && (addr == REG_RBR_THR_DLL) && !lcr_q.dlab;
  assign tx_data_o = pwdata_i[7:0];
  assign tx_clr_o  = tx_clr_q;
  assign rx_clr_o  = rx_clr_q;
  assign rx_pop_o  = rd_en && (addr == REG_RBR_THR_DLL) && !lcr_q.dlab && rx_valid_i;

  // line settings out
  assign line.div      = {dlm_q, dll_q};
  assign line.wlen     = lcr_q.wlen;
  assign line.par_en   = lcr_q.par_en;
  assign line.even_par = lcr_q.even_par;
  assign line.stop2    = lcr_q.stop2;

  //////////////////////////////////////////////////
  // status and interrupt
  //////////////////////////////////////////////////
  always_comb begin
    case (trig_q)
      2'd0:    trig_lvl = CW'(1);
      2'd1:    trig_lvl = CW'(4);
      2'd2:    trig_lvl = CW'(8);
      default: trig_lvl = CW'(14);
    endcase
  end

  assign lsr = {1'b0,
                (tx_count_i == '0) && tx_idle_i,   // temt
                (tx_count_i == '0),                // thre
                2'b00,
                rx_valid_i && rx_head_i.par_err,   // head has bad parity
                1'b0,
                rx_valid_i};                       // data ready

  always_comb begin
    if (ier_q[2] && rx_valid_i && rx_head_i.par_err) iir = IIR_LINE;
    else if (ier_q[0] && (rx_count_i >= trig_lvl))   iir = IIR_RDA;
    else if (ier_q[1] && (tx_count_i == '0))         iir = IIR_THRE;
    else                                             iir = IIR_NONE;
  end

  assign event_o = (iir != IIR_NONE);

  // read mux
  always_comb begin
    prdata_o = '0;
    if (rd_en) begin
      case (addr)
        REG_RBR_THR_DLL: prdata_o[7:0] = lcr_q.dlab ? dll_q : rx_head_i.data;
        REG_IER_DLM:     prdata_o[7:0] = lcr_q.dlab ? dlm_q : {5'b0, ier_q};
        REG_IIR_FCR:     prdata_o[7:0] = {4'b1100, iir};
        REG_LCR:         prdata_o[7:0] = lcr_q;
        REG_LSR:         prdata_o[7:0] = lsr;
        default:         prdata_o      = '0;
      endcase
    end
  end

endmodule

// ==== uart_apb_top.sv ====
//////////////////////////////////////////////////
// 16550 style UART on an APB-lite slave port
// PREADY is always 1 and PSLVERR always 0
// MCR, MSR, SCR and modem lines are absent
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_apb_top (
  input  logic                    CLK,
  input  logic                    RSTN,
  input  logic [`UART_APB_AW-1:0] PADDR,
  input  logic [`UART_APB_DW-1:0] PWDATA,
  input  logic                    PWRITE,
  input  logic                    PSEL,
  input  logic                    PENABLE,
  output logic [`UART_APB_DW-1:0] PRDATA,
  output logic                    PREADY,
  output logic                    PSLVERR,
  input  logic                    rx_i,
  output logic                    tx_o,
  output logic                    event_o   // level interrupt
);
  import uart_pkg::*;

  localparam int CW = $clog2(`UART_FIFO_DEPTH) + 1;

  logic          tx_push, tx_clr, tx_take, tx_idle, tx_valid;
  logic [7:0]    tx_wdata, tx_head;
  logic [CW-1:0] tx_count;
  logic          rx_pop, rx_clr, rx_push, rx_valid;
  rx_entry_t     rx_entry, rx_head;
  logic [CW-1:0] rx_count;

  uart_line_if line_if ();

  uart_regs u_regs (
    .CLK        (CLK),
    .RSTN       (RSTN),
    .paddr_i    (PADDR),
    .pwdata_i   (PWDATA),
    .pwrite_i   (PWRITE),
    .psel_i     (PSEL),
    .penable_i  (PENABLE),
    .prdata_o   (PRDATA),
    .line       (line_if),
    .tx_push_o  (tx_push),
    .tx_data_o  (tx_wdata),
    .tx_clr_o   (tx_clr),
    .tx_count_i (tx_count),
    .tx_idle_i  (tx_idle),
    .rx_pop_o   (rx_pop),
    .rx_clr_o   (rx_clr),
    .rx_head_i  (rx_head),
    .rx_valid_i (rx_valid),
    .rx_count_i (rx_count),
    .event_o    (event_o)
  );

  // tx path
  uart_fifo #(.payload_t(logic [7:0]), .DEPTH(`UART_FIFO_DEPTH)) u_tx_fifo (
    .CLK (CLK), .RSTN (RSTN), .clr_i (tx_clr),
    .push_i (tx_push), .data_i (tx_wdata), .pop_i (tx_take),
    .data_o (tx_head), .valid_o (tx_valid), .count_o (tx_count)
  );

  uart_tx u_tx (
    .CLK (CLK), .RSTN (RSTN), .line (line_if),
    .data_i (tx_head), .valid_i (tx_valid),
    .take_o (tx_take), .idle_o (tx_idle), .tx_o (tx_o)
  );

  // rx path, a full fifo drops the frame
  uart_rx u_rx (
    .CLK (CLK), .RSTN (RSTN), .line (line_if),
    .rx_i (rx_i), .push_o (rx_push), .entry_o (rx_entry)
  );

  uart_fifo #(.payload_t(rx_entry_t), .DEPTH(`UART_FIFO_DEPTH)) u_rx_fifo (
    .CLK (CLK), .RSTN (RSTN), .clr_i (rx_clr),
    .push_i (rx_push), .data_i (rx_entry), .pop_i (rx_pop),
    .data_o (rx_head), .valid_o (rx_valid), .count_o (rx_count)
  );

  assign PREADY  = 1'b1;   // no wait states
  assign PSLVERR = 1'b0;

endmodule

// ==== tb_uart.sv ====
//////////////////////////////////////////////////
// directed testbench for the APB UART
// divisor 7 gives 8 clocks per serial bit
// loop_en ties tx_o back to rx_i, else the
// serial driver below owns the rx line
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "uart_cfg.svh"

module tb_uart;
  import uart_pkg::*;

  localparam int BIT_CYC = 8;      // div+1 with div of 7

  logic                    CLK;
  logic                    RSTN;
  logic [`UART_APB_AW-1:0] paddr;
  logic [`UART_APB_DW-1:0] pwdata;
  logic                    pwrite;
  logic                    psel;
  logic                    penable;
  logic [`UART_APB_DW-1:0] prdata;
  logic                    pready;
  logic                    pslverr;
  logic                    tx_line;
  logic                    rx_line;
  logic                    drv_line;   // serial driver output
  logic                    loop_en;
  logic                    irq;
  lcr_t                    cur_lcr;    // mirror of the programmed LCR
  logic [15:0]             lfsr_q;

  assign rx_line = loop_en ? tx_line : drv_line;

  uart_apb_top uut (
    .CLK     (CLK),
    .RSTN    (RSTN),
    .PADDR   (paddr),
    .PWDATA  (pwdata),
    .PWRITE  (pwrite),
    .PSEL    (psel),
    .PENABLE (penable),
    .PRDATA  (prdata),
    .PREADY  (pready),
    .PSLVERR (pslverr),
    .rx_i    (rx_line),
    .tx_o    (tx_line),
    .event_o (irq)
  );

  always #4 CLK = ~CLK;   // 8 ns period

  //////////////////////////////////////////////////
  // checks and timeouts
  //////////////////////////////////////////////////
  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("ERROR at %0t ns: timed out waiting for %s", $time, what);
    $display("TESTBENCH FAILED");
    $fatal(1, "wait timeout");
  endtask

  //////////////////////////////////////////////////
  // apb master
  //////////////////////////////////////////////////
  task automatic apb_write(input logic [2:0] off, input logic [7:0] data);
    @(posedge CLK);
    psel    <= 1'b1;
    pwrite  <= 1'b1;
    paddr   <= `UART_APB_AW'(off);
    pwdata  <= `UART_APB_DW'(data);
    @(posedge CLK);
    penable <= 1'b1;            // access phase
    @(posedge CLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [2:0] off, output logic [31:0] data);
    @(posedge CLK);
    psel    <= 1'b1;
    pwrite  <= 1'b0;
    paddr   <= `UART_APB_AW'(off);
    @(posedge CLK);
    penable <= 1'b1;
    @(negedge CLK);             // prdata settled mid access
    data = prdata;
    check_eq("PREADY", pready, 1);
    check_eq("PSLVERR", pslverr, 0);
    @(posedge CLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_check(input logic [2:0] off, input logic [31:0] exp, input string name);
    logic [31:0] d;
    apb_read(off, d);
    check_eq(name, d, exp);
  endtask

  task automatic set_lcr(input logic [7:0] val);
    apb_write(REG_LCR, val);
    cur_lcr = val;
  endtask

  // poll an LSR bit until it reads 1
  task automatic wait_lsr(input int bit_idx, input int limit, input string what);
    logic [31:0] d;
    bit          seen;
    seen = 1'b0;
    for (int i = 0; i < limit && !seen; i++) begin
      apb_read(REG_LSR, d);
      if (d[bit_idx]) seen = 1'b1;
    end
    if (!seen) report_timeout(what);
  endtask

  task automatic wait_irq(input int limit);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < limit && !seen; i++) begin
      @(negedge CLK);
      if (irq) seen = 1'b1;
    end
    if (!seen) report_timeout("event_o high");
  endtask

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_byte(output logic [7:0] b);
    b = '0;
    for (int i = 0; i < 8; i++) begin   // one step per bit
      lfsr_q = lfsr_next(lfsr_q);
      b      = {b[6:0], lfsr_q[0]};
    end
  endtask

  // low 5+wlen bits set
  function automatic logic [7:0] word_mask(input logic [1:0] wlen);
    int nbits;
    nbits = 5 + wlen;
    return 8'((1 << nbits) - 1);
  endfunction

  // raw bits on the rx line, bit 0 first
  task automatic send_bits(input logic [11:0] bits, input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge CLK);
      drv_line <= bits[i];
      repeat (BIT_CYC - 1) @(posedge CLK);
    end
  endtask

  // one frame in the current LCR format, bad_par flips parity
  task automatic send_char(input logic [7:0] data, input logic bad_par);
    logic [11:0] bits;
    logic [7:0]  md;
    logic        par;
    int          n;
    md   = data & word_mask(cur_lcr.wlen);
    bits = '1;
    bits[0] = 1'b0;                       // start
    n    = 1;
    for (int i = 0; i < 5 + cur_lcr.wlen; i++) begin
      bits[n] = md[i];
      n++;
    end
    if (cur_lcr.par_en) begin
      par     = (^md) ^ ~cur_lcr.even_par;  // even: total ones even
      bits[n] = par ^ bad_par;
      n++;
    end
    n = n + (cur_lcr.stop2 ? 2 : 1);      // stop bits already 1
    send_bits(bits, n);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////
  task automatic test_reset_values();
    read_check(REG_LSR, 32'h60, "LSR");
    read_check(REG_IIR_FCR, 32'hC1, "IIR");
    read_check(REG_LCR, 32'h00, "LCR");
    read_check(REG_IER_DLM, 32'h00, "IER");
    @(negedge CLK);
    check_eq("tx_o", tx_line, 1);
    check_eq("event_o", irq, 0);
  endtask

  task automatic test_divisor();
    set_lcr(8'h80);                       // dlab
    apb_write(REG_RBR_THR_DLL, 8'h5A);
    apb_write(REG_IER_DLM, 8'h3C);
    read_check(REG_RBR_THR_DLL, 32'h5A, "DLL");
    read_check(REG_IER_DLM, 32'h3C, "DLM");
    apb_write(REG_RBR_THR_DLL, 8'd7);     // divisor 7 for the rest
    apb_write(REG_IER_DLM, 8'd0);
    set_lcr(8'h00);
    apb_write(REG_IER_DLM, 8'h05);        // differs from DLM
    read_check(REG_IER_DLM, 32'h05, "IER");
    apb_write(REG_IER_DLM, 8'h00);
  endtask

  task automatic test_loopback();
    logic [7:0]  b;
    logic [31:0] d;
    loop_en <= 1'b1;
    for (int f = 0; f < 2; f++) begin
      set_lcr(f == 0 ? 8'h03 : 8'h1E);    // 8N1, then 7E2
      for (int k = 0; k < 10; k++) begin
        next_byte(b);
        apb_write(REG_RBR_THR_DLL, b);
        wait_lsr(0, 400, "rx data ready");
        apb_read(REG_LSR, d);
        check_eq("LSR parity error", d[2], 0);
        read_check(REG_RBR_THR_DLL, b & word_mask(cur_lcr.wlen), "RBR");
      end
      wait_lsr(6, 400, "transmitter empty");
    end
  endtask

  task automatic test_parity_error();
    @(posedge CLK);
    loop_en <= 1'b0;
    set_lcr(8'h1B);                       // 8 bits, even parity
    send_char(8'hA5, 1'b1);
    wait_lsr(0, 100, "rx data ready");
    read_check(REG_LSR, 32'h65, "LSR");
    @(negedge CLK);
    check_eq("event_o", irq, 0);
    apb_write(REG_IER_DLM, 8'h04);
    read_check(REG_IIR_FCR, 32'hC6, "IIR");
    @(negedge CLK);
    check_eq("event_o", irq, 1);
    read_check(REG_RBR_THR_DLL, 32'hA5, "RBR");
    read_check(REG_LSR, 32'h60, "LSR");
    @(negedge CLK);
    check_eq("event_o", irq, 0);
  endtask

  task automatic test_rx_trigger();
    logic [7:0] sent [4];
    set_lcr(8'h03);
    apb_write(REG_IIR_FCR, 8'h40);        // trigger level 4
    apb_write(REG_IER_DLM, 8'h01);
    for (int k = 0; k < 3; k++) begin
      next_byte(sent[k]);
      send_char(sent[k], 1'b0);
    end
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    check_eq("event_o", irq, 0);
    next_byte(sent[3]);
    send_char(sent[3], 1'b0);
    wait_irq(4 * BIT_CYC);
    read_check(REG_IIR_FCR, 32'hC4, "IIR");
    for (int k = 0; k < 4; k++) read_check(REG_RBR_THR_DLL, sent[k], "RBR");
    @(negedge CLK);
    check_eq("event_o", irq, 0);
  endtask

  task automatic test_fifo_clear();
    logic [7:0] b;
    apb_write(REG_IER_DLM, 8'h00);
    loop_en <= 1'b1;
    for (int k = 0; k < 3; k++) begin
      next_byte(b);
      apb_write(REG_RBR_THR_DLL, b);
    end
    wait_lsr(6, 600, "transmitter empty");
    read_check(REG_LSR, 32'h61, "LSR");   // three bytes held
    @(posedge CLK);
    loop_en <= 1'b0;
    for (int k = 0; k < 3; k++) begin
      next_byte(b);
      apb_write(REG_RBR_THR_DLL, b);
    end
    apb_write(REG_IIR_FCR, 8'h06);        // clear both fifos
    read_check(REG_LSR, 32'h20, "LSR");   // frame still on the wire
    wait_lsr(6, 400, "transmitter empty");
    read_check(REG_LSR, 32'h60, "LSR");
    apb_write(REG_IER_DLM, 8'h02);
    @(negedge CLK);
    check_eq("event_o", irq, 1);
    read_check(REG_IIR_FCR, 32'hC2, "IIR");
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    CLK      = 1'b0;
    RSTN     = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    pwrite   = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    drv_line = 1'b1;   // idle line
    loop_en  = 1'b0;
    cur_lcr  = '0;
    lfsr_q   = 16'd44543;
    repeat (4) @(posedge CLK);
    RSTN <= 1'b1;
    test_reset_values();
    test_divisor();
    test_loopback();
    test_parity_error();
    test_rx_trigger();
    test_fifo_clear();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== uart_apb_top.f ====
+incdir+.
uart_pkg.sv
uart_line_if.sv
uart_baud_timer.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_regs.sv
uart_apb_top.sv
tb_uart.sv
